// File: list.f
hw/loader_pkg.sv
hw/prg_loader.sv
hw/crt_loader.sv
hw/sdram_write_slot.sv
hw/c64_loader_top.sv
verif/c64_loader_tb.sv

// File: Bender.yml
package:
  name: c64_loader

sources:
  - files:
      - hw/loader_pkg.sv
      - hw/prg_loader.sv
      - hw/crt_loader.sv
      - hw/sdram_write_slot.sv
      - hw/c64_loader_top.sv
  - target: simulation
    files:
      - verif/c64_loader_tb.sv

// File: verif/c64_loader_tb.sv
`timescale 1ns/1ps
`default_nettype none

module c64_loader_tb;

	import loader_pkg::*;

	localparam int          WAIT_LIMIT    = 2000;
	localparam int          PRG_LEN       = 40;
	localparam int          CHIP_LEN      = 32;
	localparam int          PTR_WRITES    = 12;
	localparam c64_addr_t   PRG_LOAD_ADDR = 16'h0801;
	localparam sdram_addr_t CART_SDRAM    = 25'h100000;

	logic        clk_sys = 1'b0;
	logic        reset_n;
	logic        ioctl_download_i;
	file_index_t ioctl_index_i;
	logic        ioctl_wr_i;
	sdram_addr_t ioctl_addr_i;
	byte_t       ioctl_data_i;
	logic        ioctl_wait_o;
	logic        io_cycle_i;
	logic        mem_ce_o;
	logic        mem_we_o;
	sdram_addr_t mem_addr_o;
	byte_t       mem_data_o;
	logic        cart_attached_o;
	logic [15:0] cart_id_o;
	byte_t       cart_exrom_o;
	byte_t       cart_game_o;
	logic        bank_wr_o;
	byte_t       bank_type_o;
	c64_addr_t   bank_num_o;
	c64_addr_t   bank_laddr_o;
	c64_addr_t   bank_size_o;
	sdram_addr_t bank_raddr_o;
	logic        inj_done_o;

	// SDRAM model and expected data
	byte_t       sdram [sdram_addr_t];
	byte_t       prg_payload [PRG_LEN];
	byte_t       chip_payload [2][CHIP_LEN];
	byte_t       exp_bank_type [2];
	c64_addr_t   exp_bank_laddr [2];
	logic [31:0] lfsr_state;
	logic [1:0]  io_hist;
	logic        we_seen;
	logic        long_high;
	sdram_addr_t file_pos;
	int          write_count;
	int          bank_count;
	int          inj_done_count;
	int          stall_count;
	int          error_count;
	int          test_errors;
	int          test_count;
	int          failed_tests;

	c64_loader_top c64_loader_top_inst (.*);

	initial begin
		forever #2 clk_sys = ~clk_sys;
	end

	//==========================================================================
	// Helpers
	//==========================================================================

	task automatic report_mismatch(input string msg);
		error_count++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timeout at %0t: %s", $time, what);
		$display("Errors found");
		$finish;
	endtask

	task automatic finish_test(input string name);
		test_count++;
		if (error_count == test_errors) begin
			$display("Test %0d %s: passed", test_count, name);
		end else begin
			failed_tests++;
			$display("Test %0d %s: failed", test_count, name);
		end
		test_errors = error_count;
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h80200003;
		end
		return state >> 1;
	endfunction

	// One LFSR step per bit taken
	task automatic draw_bits(input int count, output byte_t value);
		value = '0;
		for (int k = 0; k < count; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[6:0], lfsr_state[0]};
		end
	endtask

	// Machine bus cycles, write slot opens on each falling edge
	task automatic drive_io_cycle();
		byte_t high_len;
		byte_t low_len;
		forever begin
			draw_bits(2, high_len);
			draw_bits(1, low_len);
			io_cycle_i = 1'b1;
			repeat (3 + int'(high_len) + (long_high ? 12 : 0)) @(posedge clk_sys);
			#1;
			io_cycle_i = 1'b0;
			repeat (5 + int'(low_len)) @(posedge clk_sys);
			#1;
		end
	endtask

	task automatic host_write(input sdram_addr_t addr, input byte_t data);
		int cycles;
		cycles = 0;
		if (ioctl_wait_o) begin
			stall_count++;
		end
		while (ioctl_wait_o) begin
			@(posedge clk_sys);
			#1;
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				abort_on_timeout("ioctl_wait_o stayed high");
			end
		end
		ioctl_addr_i = addr;
		ioctl_data_i = data;
		ioctl_wr_i   = 1'b1;
		@(posedge clk_sys);
		#1;
		ioctl_wr_i = 1'b0;
		// Request needs a clock before it shows as ioctl_wait_o
		@(posedge clk_sys);
		#1;
	endtask

	task automatic stream_byte(input byte_t data);
		host_write(file_pos, data);
		file_pos = file_pos + 1'b1;
	endtask

	// CRT fields are big-endian
	task automatic stream_word(input logic [15:0] word);
		stream_byte(word[15:8]);
		stream_byte(word[7:0]);
	endtask

	task automatic check_mem(input sdram_addr_t addr, input byte_t exp);
		byte_t got;
		got = 'x;
		if (sdram.exists(addr)) begin
			got = sdram[addr];
		end
		assert (got === exp)
		else report_mismatch($sformatf("SDRAM %h holds %h, expected %h", addr, got, exp));
	endtask

	//==========================================================================
	// Monitors
	//==========================================================================

	always @(posedge clk_sys) begin
		io_hist = {io_hist[0], io_cycle_i};
	end

	always @(negedge clk_sys) begin
		if (reset_n) begin
			assert (mem_ce_o == mem_we_o)
			else report_mismatch("mem_ce_o and mem_we_o differ");
			assert (!(io_hist == 2'b11 && mem_we_o))
			else report_mismatch("write strobe high after two io_cycle_i high samples");
			if (mem_we_o && !we_seen) begin
				sdram[mem_addr_o] = mem_data_o;
				write_count++;
			end
			we_seen = mem_we_o;
			if (inj_done_o) begin
				inj_done_count++;
			end
			if (bank_wr_o && bank_count < 2) begin
				assert (bank_type_o == exp_bank_type[bank_count]
					&& bank_num_o == 16'(bank_count)
					&& bank_laddr_o == exp_bank_laddr[bank_count]
					&& bank_size_o == 16'(CHIP_LEN)
					&& bank_raddr_o == CART_SDRAM + sdram_addr_t'(bank_count * 'h2000))
				else report_mismatch($sformatf("bank %0d type %h num %h laddr %h size %h raddr %h",
					bank_count, bank_type_o, bank_num_o, bank_laddr_o, bank_size_o, bank_raddr_o));
			end
			if (bank_wr_o) begin
				bank_count++;
			end
		end
	end

	//==========================================================================
	// Stimulus
	//==========================================================================

	initial begin
		int        i;
		int        n;
		int        cycles;
		byte_t     b;
		c64_addr_t prg_end;

		reset_n          = 1'b0;
		ioctl_download_i = 1'b0;
		ioctl_index_i    = '0;
		ioctl_wr_i       = 1'b0;
		ioctl_addr_i     = '0;
		ioctl_data_i     = '0;
		io_cycle_i       = 1'b0;
		long_high        = 1'b0;
		io_hist          = '0;
		we_seen          = 1'b0;
		file_pos         = '0;
		write_count      = 0;
		bank_count       = 0;
		inj_done_count   = 0;
		stall_count      = 0;
		error_count      = 0;
		test_errors      = 0;
		test_count       = 0;
		failed_tests     = 0;
		lfsr_state       = 32'h1ddabdfd;
		exp_bank_type    = '{8'h00, 8'h02};
		exp_bank_laddr   = '{16'h8000, 16'hA000};
		for (i = 0; i < PRG_LEN; i++) begin
			draw_bits(8, prg_payload[i]);
		end
		for (n = 0; n < 2; n++) begin
			for (i = 0; i < CHIP_LEN; i++) begin
				draw_bits(8, chip_payload[n][i]);
			end
		end

		repeat (8) @(posedge clk_sys);
		#1;
		reset_n = 1'b1;
		repeat (6) begin
			@(negedge clk_sys);
			assert (!(mem_ce_o || mem_we_o || ioctl_wait_o || bank_wr_o || inj_done_o
				|| cart_attached_o))
			else report_mismatch("control output high after reset");
		end
		finish_test("reset state");

		// PRG download
		@(posedge clk_sys);
		#1;
		fork
			drive_io_cycle();
		join_none
		ioctl_index_i    = FILE_PRG;
		ioctl_download_i = 1'b1;
		file_pos         = '0;
		stream_word({PRG_LOAD_ADDR[7:0], PRG_LOAD_ADDR[15:8]});
		for (i = 0; i < PRG_LEN; i++) begin
			stream_byte(prg_payload[i]);
		end
		ioctl_download_i = 1'b0;
		cycles = 0;
		while (inj_done_count == 0) begin
			@(posedge clk_sys);
			#1;
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				abort_on_timeout("inj_done_o never pulsed after the PRG download");
			end
		end
		for (i = 0; i < PRG_LEN; i++) begin
			check_mem(sdram_addr_t'(PRG_LOAD_ADDR) + sdram_addr_t'(i), prg_payload[i]);
		end
		finish_test("PRG payload");

		repeat (4) @(posedge clk_sys);
		#1;
		prg_end = PRG_LOAD_ADDR + 16'(PRG_LEN);
		check_mem(25'h02B, 8'h01);
		check_mem(25'h02C, 8'h08);
		check_mem(25'h0AC, 8'h00);
		check_mem(25'h0AD, 8'h00);
		check_mem(25'h02D, prg_end[7:0]);
		check_mem(25'h02F, prg_end[7:0]);
		check_mem(25'h031, prg_end[7:0]);
		check_mem(25'h0AE, prg_end[7:0]);
		check_mem(25'h02E, prg_end[15:8]);
		check_mem(25'h030, prg_end[15:8]);
		check_mem(25'h032, prg_end[15:8]);
		check_mem(25'h0AF, prg_end[15:8]);
		assert (inj_done_count == 1)
		else report_mismatch($sformatf("inj_done_o pulsed %0d times", inj_done_count));
		finish_test("BASIC pointers");

		// CRT download with slow write slots
		long_high        = 1'b1;
		ioctl_index_i    = FILE_CRT;
		ioctl_download_i = 1'b1;
		file_pos         = '0;
		for (i = 0; i < 'h40; i++) begin
			case (i)
				'h17: b = 8'h20;
				'h19: b = 8'h01;
				default: b = 8'h00;
			endcase
			stream_byte(b);
		end
		for (n = 0; n < 2; n++) begin
			stream_word(16'h4348);
			stream_word(16'h4950);
			// Packet length counts the 16 header bytes
			stream_word(16'h0000);
			stream_word(16'(16 + CHIP_LEN));
			stream_word({8'h00, exp_bank_type[n]});
			stream_word(16'(n));
			stream_word(exp_bank_laddr[n]);
			stream_word(16'(CHIP_LEN));
			for (i = 0; i < CHIP_LEN; i++) begin
				stream_byte(chip_payload[n][i]);
			end
		end
		ioctl_download_i = 1'b0;
		cycles = 0;
		while (ioctl_wait_o) begin
			@(posedge clk_sys);
			#1;
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				abort_on_timeout("CRT download writes did not drain");
			end
		end
		repeat (2) @(posedge clk_sys);
		#1;
		assert (cart_id_o == 16'h0020 && cart_exrom_o == 8'h00 && cart_game_o == 8'h01)
		else report_mismatch($sformatf("cartridge id %h EXROM %h GAME %h",
			cart_id_o, cart_exrom_o, cart_game_o));
		assert (bank_count == 2)
		else report_mismatch($sformatf("bank_wr_o pulsed %0d times", bank_count));
		for (n = 0; n < 2; n++) begin
			for (i = 0; i < CHIP_LEN; i++) begin
				check_mem(CART_SDRAM + sdram_addr_t'(n * 'h2000 + i), chip_payload[n][i]);
			end
		end
		finish_test("CRT parse and payload");

		assert (write_count == PRG_LEN + PTR_WRITES + 2 * CHIP_LEN)
		else report_mismatch($sformatf("%0d SDRAM writes, expected %0d", write_count,
			PRG_LEN + PTR_WRITES + 2 * CHIP_LEN));
		assert (stall_count > 0)
		else report_mismatch("host was never held off by ioctl_wait_o");
		assert (cart_attached_o)
		else report_mismatch("cart_attached_o low after the CRT download");
		finish_test("back-pressure and write count");

		$display("Tests run: %0d, tests failed: %0d, failed checks: %0d",
			test_count, failed_tests, error_count);
		if (error_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/c64_loader_top.sv
`timescale 1ns/1ps
`default_nettype none

module c64_loader_top #(
	parameter int SDRAM_AW = $bits(loader_pkg::sdram_addr_t)
) (
	input  wire                     clk_sys,
	input  wire                     reset_n,
	input  wire                     ioctl_download_i,
	input  wire loader_pkg::file_index_t ioctl_index_i,
	input  wire                     ioctl_wr_i,
	input  wire loader_pkg::sdram_addr_t ioctl_addr_i,
	input  wire loader_pkg::byte_t  ioctl_data_i,
	output logic                    ioctl_wait_o,
	input  wire                     io_cycle_i,
	output logic                    mem_ce_o,
	output logic                    mem_we_o,
	output loader_pkg::sdram_addr_t mem_addr_o,
	output loader_pkg::byte_t       mem_data_o,
	output logic                    cart_attached_o,
	output logic [15:0]             cart_id_o,
	output loader_pkg::byte_t       cart_exrom_o,
	output loader_pkg::byte_t       cart_game_o,
	output logic                    bank_wr_o,
	output loader_pkg::byte_t       bank_type_o,
	output loader_pkg::c64_addr_t   bank_num_o,
	output loader_pkg::c64_addr_t   bank_laddr_o,
	output loader_pkg::c64_addr_t   bank_size_o,
	output loader_pkg::sdram_addr_t bank_raddr_o,
	output logic                    inj_done_o
);

	import loader_pkg::*;

	logic        prg_en;
	logic        crt_en;
	logic        slot_busy;
	logic        prg_req;
	sdram_addr_t prg_addr;
	byte_t       prg_data;
	logic        crt_req;
	sdram_addr_t crt_addr;
	byte_t       crt_data;

	// File kind from the host menu index
	assign prg_en       = (ioctl_index_i == FILE_PRG);
	assign crt_en       = (ioctl_index_i == FILE_CRT);
	assign ioctl_wait_o = slot_busy;

	prg_loader prg_loader_inst (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.enable_i    (prg_en),
		.download_i  (ioctl_download_i),
		.wr_i        (ioctl_wr_i),
		.addr_i      (ioctl_addr_i),
		.data_i      (ioctl_data_i),
		.slot_busy_i (slot_busy),
		.req_o       (prg_req),
		.req_addr_o  (prg_addr),
		.req_data_o  (prg_data),
		.inj_done_o  (inj_done_o)
	);

	crt_loader crt_loader_inst (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.enable_i        (crt_en),
		.download_i      (ioctl_download_i),
		.wr_i            (ioctl_wr_i),
		.addr_i          (ioctl_addr_i),
		.data_i          (ioctl_data_i),
		.slot_busy_i     (slot_busy),
		.req_o           (crt_req),
		.req_addr_o      (crt_addr),
		.req_data_o      (crt_data),
		.cart_attached_o (cart_attached_o),
		.cart_id_o       (cart_id_o),
		.cart_exrom_o    (cart_exrom_o),
		.cart_game_o     (cart_game_o),
		.bank_wr_o       (bank_wr_o),
		.bank_type_o     (bank_type_o),
		.bank_num_o      (bank_num_o),
		.bank_laddr_o    (bank_laddr_o),
		.bank_size_o     (bank_size_o),
		.bank_raddr_o    (bank_raddr_o)
	);

	sdram_write_slot #(
		.SDRAM_AW (SDRAM_AW)
	) sdram_write_slot_inst (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.prg_req_i   (prg_req),
		.prg_addr_i  (prg_addr),
		.prg_data_i  (prg_data),
		.crt_req_i   (crt_req),
		.crt_addr_i  (crt_addr),
		.crt_data_i  (crt_data),
		.io_cycle_i  (io_cycle_i),
		.slot_busy_o (slot_busy),
		.mem_ce_o    (mem_ce_o),
		.mem_we_o    (mem_we_o),
		.mem_addr_o  (mem_addr_o),
		.mem_data_o  (mem_data_o)
	);

endmodule

`default_nettype wire

// File: hw/sdram_write_slot.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_write_slot #(
	parameter int SDRAM_AW = 25
) (
	input  wire                     clk_sys,
	input  wire                     reset_n,
	input  wire                     prg_req_i,
	input  wire loader_pkg::sdram_addr_t prg_addr_i,
	input  wire loader_pkg::byte_t  prg_data_i,
	input  wire                     crt_req_i,
	input  wire loader_pkg::sdram_addr_t crt_addr_i,
	input  wire loader_pkg::byte_t  crt_data_i,
	input  wire                     io_cycle_i,
	output logic                    slot_busy_o,
	output logic                    mem_ce_o,
	output logic                    mem_we_o,
	output logic [SDRAM_AW-1:0]     mem_addr_o,
	output loader_pkg::byte_t       mem_data_o
);

	import loader_pkg::*;

	logic                io_cycle_d;
	logic                issue;
	logic [SDRAM_AW-1:0] pend_addr;
	byte_t               pend_data;

	// Write slot opens when io_cycle drops
	assign issue = io_cycle_d && !io_cycle_i && slot_busy_o;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			io_cycle_d  <= 1'b0;
			slot_busy_o <= 1'b0;
			mem_ce_o    <= 1'b0;
			mem_we_o    <= 1'b0;
		end else begin
			io_cycle_d <= io_cycle_i;
			if (prg_req_i || crt_req_i) begin
				slot_busy_o <= 1'b1;
			end else if (issue) begin
				slot_busy_o <= 1'b0;
			end
			// Strobes end once io_cycle is seen high twice
			if (issue) begin
				mem_ce_o <= 1'b1;
				mem_we_o <= 1'b1;
			end else if (io_cycle_d && io_cycle_i) begin
				mem_ce_o <= 1'b0;
				mem_we_o <= 1'b0;
			end
		end
	end

	// PRG wins if both loaders ask at once
	always_ff @(posedge clk_sys) begin
		if (prg_req_i) begin
			pend_addr <= prg_addr_i;
			pend_data <= prg_data_i;
		end else if (crt_req_i) begin
			pend_addr <= crt_addr_i;
			pend_data <= crt_data_i;
		end
		if (issue) begin
			mem_addr_o <= pend_addr;
			mem_data_o <= pend_data;
		end
	end

endmodule

`default_nettype wire

// File: hw/crt_loader.sv
`timescale 1ns/1ps
`default_nettype none

module crt_loader (
	input  wire                     clk_sys,
	input  wire                     reset_n,
	input  wire                     enable_i,
	input  wire                     download_i,
	input  wire                     wr_i,
	input  wire loader_pkg::sdram_addr_t addr_i,
	input  wire loader_pkg::byte_t  data_i,
	input  wire                     slot_busy_i,
	output logic                    req_o,
	output loader_pkg::sdram_addr_t req_addr_o,
	output loader_pkg::byte_t       req_data_o,
	output logic                    cart_attached_o,
	output logic [15:0]             cart_id_o,
	output loader_pkg::byte_t       cart_exrom_o,
	output loader_pkg::byte_t       cart_game_o,
	output logic                    bank_wr_o,
	output loader_pkg::byte_t       bank_type_o,
	output loader_pkg::c64_addr_t   bank_num_o,
	output loader_pkg::c64_addr_t   bank_laddr_o,
	output loader_pkg::c64_addr_t   bank_size_o,
	output loader_pkg::sdram_addr_t bank_raddr_o
);

	import loader_pkg::*;

	// Byte counts within a chip header
	localparam logic [3:0] HDR_LEN_FIRST = 4'd4;
	localparam logic [3:0] HDR_LEN_LAST  = 4'd7;
	localparam logic [3:0] HDR_TYPE      = 4'd9;
	localparam logic [3:0] HDR_NUM_HI    = 4'd10;
	localparam logic [3:0] HDR_NUM_LO    = 4'd11;
	localparam logic [3:0] HDR_LADDR_HI  = 4'd12;
	localparam logic [3:0] HDR_LADDR_LO  = 4'd13;
	localparam logic [3:0] HDR_SIZE_HI   = 4'd14;
	localparam logic [3:0] HDR_SIZE_LO   = 4'd15;

	crt_state_t  state;
	logic [3:0]  hdr_cnt;
	logic [31:0] blk_len;
	sdram_addr_t wr_addr;
	sdram_addr_t wr_addr_aligned;
	logic        download_d;
	logic        req_hold;
	logic        host_wr;
	logic        chip_byte;

	assign host_wr   = wr_i && enable_i;
	assign chip_byte = host_wr && (addr_i >= CRT_CHIP_START);

	// Round up to the next 8 KB boundary
	assign wr_addr_aligned = (wr_addr[12:0] == '0) ? wr_addr :
		{wr_addr[24:13] + 1'b1, 13'h0000};

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state           <= CRT_FILE_HDR;
			hdr_cnt         <= '0;
			download_d      <= 1'b0;
			req_o           <= 1'b0;
			req_hold        <= 1'b0;
			bank_wr_o       <= 1'b0;
			cart_attached_o <= 1'b0;
		end else begin
			download_d <= download_i;
			req_o      <= 1'b0;
			bank_wr_o  <= 1'b0;

			// Low while a cartridge streams in, high once it has ended
			if (enable_i && (download_d != download_i)) begin
				cart_attached_o <= download_d;
			end

			// A payload byte that met a busy slot goes out when it frees
			if (req_hold && !slot_busy_i) begin
				req_o    <= 1'b1;
				req_hold <= 1'b0;
			end

			if (host_wr && addr_i == '0) begin
				state   <= CRT_FILE_HDR;
				hdr_cnt <= '0;
				wr_addr <= CRT_BASE;
			end

			if (chip_byte) begin
				case (state)
					CRT_CHIP_HDR: begin
						hdr_cnt <= hdr_cnt + 1'b1;
						if (hdr_cnt >= HDR_LEN_FIRST && hdr_cnt < HDR_LEN_LAST) begin
							blk_len <= {blk_len[23:0], data_i};
						end
						// Last length byte, keep only the payload part
						if (hdr_cnt == HDR_LEN_LAST) begin
							blk_len <= {blk_len[23:0], data_i} - CRT_CHIP_HDR_LEN;
						end
						if (hdr_cnt == HDR_SIZE_LO) begin
							state     <= CRT_PAYLOAD;
							hdr_cnt   <= '0;
							bank_wr_o <= 1'b1;
						end
					end

					CRT_PAYLOAD: begin
						if (blk_len != '0) begin
							blk_len    <= blk_len - 1'b1;
							wr_addr    <= wr_addr + 1'b1;
							req_addr_o <= wr_addr;
							req_data_o <= data_i;
							req_hold   <= slot_busy_i;
							req_o      <= !slot_busy_i;
						end else begin
							state   <= CRT_CHIP_HDR;
							hdr_cnt <= 4'd1;
							wr_addr <= wr_addr_aligned;
						end
					end

					// First chip header after the file header
					default: begin
						state   <= CRT_CHIP_HDR;
						hdr_cnt <= 4'd1;
						wr_addr <= wr_addr_aligned;
					end
				endcase
			end
		end
	end

	// Cartridge and bank fields
	always_ff @(posedge clk_sys) begin
		if (host_wr) begin
			case (addr_i)
				CRT_HDR_ID_HI: cart_id_o[15:8] <= data_i;
				CRT_HDR_ID_LO: cart_id_o[7:0]  <= data_i;
				CRT_HDR_EXROM: cart_exrom_o    <= data_i;
				CRT_HDR_GAME:  cart_game_o     <= data_i;
				default: ;
			endcase
		end
		if (chip_byte && state == CRT_CHIP_HDR) begin
			case (hdr_cnt)
				HDR_TYPE:     bank_type_o        <= data_i;
				HDR_NUM_HI:   bank_num_o[15:8]   <= data_i;
				HDR_NUM_LO:   bank_num_o[7:0]    <= data_i;
				HDR_LADDR_HI: bank_laddr_o[15:8] <= data_i;
				HDR_LADDR_LO: bank_laddr_o[7:0]  <= data_i;
				HDR_SIZE_HI:  bank_size_o[15:8]  <= data_i;
				HDR_SIZE_LO: begin
					bank_size_o[7:0] <= data_i;
					bank_raddr_o     <= wr_addr;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/prg_loader.sv
`timescale 1ns/1ps
`default_nettype none

module prg_loader (
	input  wire                     clk_sys,
	input  wire                     reset_n,
	input  wire                     enable_i,
	input  wire                     download_i,
	input  wire                     wr_i,
	input  wire loader_pkg::sdram_addr_t addr_i,
	input  wire loader_pkg::byte_t  data_i,
	input  wire                     slot_busy_i,
	output logic                    req_o,
	output loader_pkg::sdram_addr_t req_addr_o,
	output loader_pkg::byte_t       req_data_o,
	output logic                    inj_done_o
);

	import loader_pkg::*;

	prg_state_t state;
	c64_addr_t  end_addr;
	logic [8:0] fill_addr;
	logic       fill_step;
	logic       ptr_hit;
	byte_t      ptr_data;

	// One sweep step per free slot, never while a request is in flight
	assign fill_step = (state == PRG_PTR_FILL) && !slot_busy_i && !req_o;

	// BASIC pointer bytes, as a LOAD command would leave them
	always_comb begin
		ptr_hit  = 1'b1;
		ptr_data = 8'h00;
		case (fill_addr)
			9'h02B: ptr_data = 8'h01;
			9'h02C: ptr_data = 8'h08;
			9'h0AC, 9'h0AD: ptr_data = 8'h00;
			// VAR, ARY, STR and load end all point past the program
			9'h02D, 9'h02F, 9'h031, 9'h0AE: ptr_data = end_addr[7:0];
			9'h02E, 9'h030, 9'h032, 9'h0AF: ptr_data = end_addr[15:8];
			default: ptr_hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state      <= PRG_IDLE;
			req_o      <= 1'b0;
			inj_done_o <= 1'b0;
		end else begin
			req_o      <= 1'b0;
			inj_done_o <= 1'b0;

			// Host bytes, header first then payload
			if (wr_i && enable_i && state != PRG_PTR_FILL) begin
				// end_addr starts out as the load address
				if (addr_i == '0) begin
					end_addr[7:0] <= data_i;
				end else if (addr_i == sdram_addr_t'(1)) begin
					end_addr[15:8] <= data_i;
				end else begin
					req_o      <= 1'b1;
					req_addr_o <= sdram_addr_t'(end_addr);
					req_data_o <= data_i;
					end_addr   <= end_addr + 1'b1;
				end
			end

			case (state)
				PRG_IDLE: begin
					if (enable_i && download_i) begin
						state <= PRG_LOAD;
					end
				end

				PRG_LOAD: begin
					// Download over, patch zero page
					if (!download_i) begin
						state     <= PRG_PTR_FILL;
						fill_addr <= '0;
					end
				end

				PRG_PTR_FILL: begin
					if (fill_step) begin
						if (fill_addr == BASIC_PTR_END) begin
							state      <= PRG_IDLE;
							inj_done_o <= 1'b1;
						end else begin
							req_o      <= ptr_hit;
							req_addr_o <= sdram_addr_t'(fill_addr);
							req_data_o <= ptr_data;
							fill_addr  <= fill_addr + 1'b1;
						end
					end
				end

				default: state <= PRG_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/loader_pkg.sv
`default_nettype none

package loader_pkg;

	//==========================================================================
	// Widths
	//==========================================================================

	typedef logic [24:0] sdram_addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] c64_addr_t;
	typedef logic [7:0]  file_index_t;

	// Host file indices
	localparam file_index_t FILE_PRG = 8'd4;
	localparam file_index_t FILE_CRT = 8'd5;

	//==========================================================================
	// CRT layout
	//==========================================================================

	// Chip payloads go from here upward, each on an 8 KB boundary
	localparam sdram_addr_t CRT_BASE = 25'h100000;

	// File header fields
	localparam sdram_addr_t CRT_HDR_ID_HI  = 25'h16;
	localparam sdram_addr_t CRT_HDR_ID_LO  = 25'h17;
	localparam sdram_addr_t CRT_HDR_EXROM  = 25'h18;
	localparam sdram_addr_t CRT_HDR_GAME   = 25'h19;
	localparam sdram_addr_t CRT_CHIP_START = 25'h40;

	// Header bytes included in the chip packet length
	localparam logic [31:0] CRT_CHIP_HDR_LEN = 32'd16;

	// Zero page sweep ends here
	localparam logic [8:0] BASIC_PTR_END = 9'h100;

	//==========================================================================
	// FSM states
	//==========================================================================

	typedef enum logic [1:0] {PRG_IDLE, PRG_LOAD, PRG_PTR_FILL} prg_state_t;

	typedef enum logic [1:0] {CRT_FILE_HDR, CRT_CHIP_HDR, CRT_PAYLOAD} crt_state_t;

endpackage

`default_nettype wire
